//--- design/disp_if.sv
// ################################################
// display slot interface
// one pixel slot of sync, control, position and colour
// ################################################

`timescale 1ns/1ps

interface disp_if import display_timing_pkg::*, pattern_pkg::*; ();

    logic    hsync;   // horizontal sync, active low
    logic    vsync;   // vertical sync, active low
    logic    de;      // data enable, high in active area
    logic    frame;   // first slot of a frame
    logic    line;    // first slot of a line
    coord_t  sx;      // horizontal position
    coord_t  sy;      // vertical position
    rgb565_t rgb;     // pixel colour

    // stage that produces the slot
    modport src (
        output hsync, vsync, de, frame, line, sx, sy, rgb
    );

    // stage that consumes the slot
    modport snk (
        input  hsync, vsync, de, frame, line, sx, sy, rgb
    );

endinterface

//--- design/display_272p.sv
// ################################################
// 480x272p60 timing generator
// raster counters, registered sync, control and position
// ################################################

`timescale 1ns/1ps

module display_272p import display_timing_pkg::*; (
    input  logic clk_pix,    // pixel clock
    input  logic rst_pix,    // sync reset, active high
    disp_if.src  t_if        // first pipeline stage output
);

    coord_t x;   // raster column
    coord_t y;   // raster row

    // raster position, wraps at the end of the active area
    always_ff @(posedge clk_pix) begin
        if (x == HA_END) begin           // last pixel of the line
            x <= coord_t'(H_STA);
            y <= (y == VA_END) ? coord_t'(V_STA) : y + 1'b1;   // last line wraps to top
        end else begin
            x <= x + 1'b1;
        end
        if (rst_pix) begin
            x <= coord_t'(H_STA);
            y <= coord_t'(V_STA);
        end
    end

    // negative polarity syncs
    always_ff @(posedge clk_pix) begin
        t_if.hsync <= ~(x > HS_STA && x <= HS_END);
        t_if.vsync <= ~(y > VS_STA && y <= VS_END);
        if (rst_pix) begin
            t_if.hsync <= 1'b1;          // idle high
            t_if.vsync <= 1'b1;
        end
    end

    // control strobes
    always_ff @(posedge clk_pix) begin
        t_if.de    <= (y >= VA_STA && x >= HA_STA);
        t_if.frame <= (y == V_STA && x == H_STA);    // top left corner of blanking
        t_if.line  <= (x == H_STA);
        if (rst_pix) begin
            t_if.de    <= 1'b0;
            t_if.frame <= 1'b0;
            t_if.line  <= 1'b0;
        end
    end

    // position delayed one clock to line up with the strobes
    always_ff @(posedge clk_pix) begin
        t_if.sx <= x;
        t_if.sy <= y;
        if (rst_pix) begin
            t_if.sx <= coord_t'(H_STA);
            t_if.sy <= coord_t'(V_STA);
        end
    end

    assign t_if.rgb = '0;    // colour comes from the render stage

    // active video and horizontal sync must never overlap
    a_de_hsync: assert property (
        @(posedge clk_pix) disable iff (rst_pix)
        !(t_if.de && !t_if.hsync)
    ) else $error("de high during hsync");

endmodule

//--- design/display_timing_pkg.sv
// ################################################
// display timing package
// 480x272p60 panel constants and screen coordinate type
// ################################################

package display_timing_pkg;

    localparam int CORDW = 16;                    // signed coordinate width

    typedef logic signed [CORDW-1:0] coord_t;     // screen position, negative in blanking

    // horizontal panel timing, in pixel clocks
    localparam int H_RES  = 480;                  // active pixels
    localparam int H_FP   = 2;                    // front porch
    localparam int H_SYNC = 96;                   // sync width
    localparam int H_BP   = 43;                   // back porch

    // vertical panel timing, in lines
    localparam int V_RES  = 272;                  // active lines
    localparam int V_FP   = 1;                    // front porch
    localparam int V_SYNC = 2;                    // sync width
    localparam int V_BP   = 12;                   // back porch

    // raster start points, blanking sits at negative coordinates
    localparam int H_STA  = 0 - H_FP - H_SYNC - H_BP;   // -141
    localparam int V_STA  = 0 - V_FP - V_SYNC - V_BP;   // -15

    // sync windows, open at STA, closed at END
    localparam int HS_STA = H_STA + H_FP;         // hsync starts after this x
    localparam int HS_END = HS_STA + H_SYNC;      // last x with hsync active
    localparam int VS_STA = V_STA + V_FP;         // vsync starts after this y
    localparam int VS_END = VS_STA + V_SYNC;      // last y with vsync active

    // active area
    localparam int HA_STA = 0;                    // first active x
    localparam int HA_END = H_RES - 1;            // last active x
    localparam int VA_STA = 0;                    // first active y
    localparam int VA_END = V_RES - 1;            // last active y

    // totals
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;   // 621 clocks per line
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;   // 287 lines per frame

endpackage

//--- design/display_top.sv
// ################################################
// display top level
// timing, command latch, render and output stages
// ################################################

`timescale 1ns/1ps

module display_top import display_timing_pkg::*, pattern_pkg::*; (
    input  logic      clk_pix,    // pixel clock
    input  logic      rst_pix,    // sync reset, active high
    input  logic      cmd_req,    // host command request
    input  pat_mode_t cmd_mode,   // host pattern mode
    input  pat_arg_u  cmd_arg,    // host pattern argument
    output logic      cmd_ack,    // command acknowledge
    output logic      hsync,      // panel pins
    output logic      vsync,
    output logic      de,
    output logic      frame,
    output coord_t    sx,
    output coord_t    sy,
    output rgb565_t   rgb
);

    pat_cmd_t active_cmd;   // latch to renderer

    disp_if t_if ();        // timing to render
    disp_if r_if ();        // render to output

    display_272p u_timing (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .t_if    (t_if)
    );

    pattern_cmd_latch u_latch (
        .clk_pix    (clk_pix),
        .rst_pix    (rst_pix),
        .cmd_req    (cmd_req),
        .cmd_mode   (cmd_mode),
        .cmd_arg    (cmd_arg),
        .cmd_ack    (cmd_ack),
        .frame      (t_if.frame),   // frame slot leaving the timing stage
        .active_cmd (active_cmd)
    );

    pattern_render u_render (
        .clk_pix    (clk_pix),
        .rst_pix    (rst_pix),
        .t_if       (t_if),
        .active_cmd (active_cmd),
        .r_if       (r_if)
    );

    video_out u_out (
        .clk_pix (clk_pix),
        .rst_pix (rst_pix),
        .r_if    (r_if),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame),
        .sx      (sx),
        .sy      (sy),
        .rgb     (rgb)
    );

endmodule

//--- design/pattern_cmd_latch.sv
// ################################################
// pattern command latch
// four-phase host port, command applied at frame start
// ################################################

`timescale 1ns/1ps

module pattern_cmd_latch import pattern_pkg::*; (
    input  logic      clk_pix,     // pixel clock
    input  logic      rst_pix,     // sync reset, active high
    input  logic      cmd_req,     // host request
    input  pat_mode_t cmd_mode,    // requested mode
    input  pat_arg_u  cmd_arg,     // requested argument
    output logic      cmd_ack,     // acknowledge, high from the frame start
    input  logic      frame,       // frame start from the timing stage
    output pat_cmd_t  active_cmd   // command used by the renderer
);

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for a request
        ST_PEND,     // captured, waiting for frame
        ST_ACKED     // applied, waiting for req to drop
    } lat_state_t;

    lat_state_t state;
    pat_cmd_t   pend_cmd;   // captured request
    pat_cmd_t   act_q;      // command in force
    logic       take;       // frame start with a command waiting

    assign take = (state == ST_PEND) && frame;

    // new command and ack appear in the frame slot itself
    assign active_cmd = take ? pend_cmd : act_q;
    assign cmd_ack    = take || (state == ST_ACKED);

    always_ff @(posedge clk_pix) begin
        case (state)
            ST_IDLE: begin
                if (cmd_req && !cmd_ack) state <= ST_PEND;   // both low before, new req
            end
            ST_PEND: begin
                if (frame) state <= ST_ACKED;                // defer to frame boundary
            end
            ST_ACKED: begin
                if (!cmd_req) state <= ST_IDLE;              // ack drops next clock
            end
            default: state <= ST_IDLE;
        endcase
        if (take) act_q <= pend_cmd;
        if (rst_pix) begin
            state <= ST_IDLE;
            act_q <= CMD_RESET;
        end
    end

    // host holds mode and arg stable while req is high
    always_ff @(posedge clk_pix) begin
        if (state == ST_IDLE && cmd_req) begin
            pend_cmd <= '{mode: cmd_mode, arg: cmd_arg};
        end
    end

    // an ack is only ever an answer to a live request
    a_ack_needs_req: assert property (
        @(posedge clk_pix) disable iff (rst_pix)
        $rose(cmd_ack) |-> cmd_req
    ) else $error("cmd_ack rose without cmd_req");

endmodule

//--- design/pattern_pkg.sv
// ################################################
// pattern package
// colour types, pattern modes and the command word
// ################################################

package pattern_pkg;

    // panel colour, 16 bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // compact colour used by the grid argument
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    typedef enum logic [1:0] {
        PAT_BARS  = 2'd0,    // eight fixed colour bars
        PAT_SOLID = 2'd1,    // one flat colour
        PAT_GRID  = 2'd2,    // checker grid
        PAT_RSVD  = 2'd3     // reserved, renders black
    } pat_mode_t;

    // grid view of the argument word
    typedef struct packed {
        logic [3:0] cell_log2;   // cell size as a power of two, clamped to 8
        rgb444_t    fg;          // foreground of the set cells
    } grid_arg_t;

    // one argument word, read by mode
    typedef union packed {
        rgb565_t   solid;        // PAT_SOLID colour
        grid_arg_t grid;         // PAT_GRID settings
    } pat_arg_u;

    typedef struct packed {
        pat_mode_t mode;
        pat_arg_u  arg;
    } pat_cmd_t;                 // 18 bits

    localparam int BAR_W = 60;   // bar width in pixels, 8 bars across 480

    // bars with a cleared argument
    localparam pat_cmd_t CMD_RESET = '{mode: PAT_BARS, arg: '0};

endpackage

//--- design/pattern_render.sv
// ################################################
// pattern render stage
// colour per pixel from position and active command
// ################################################

`timescale 1ns/1ps

module pattern_render import pattern_pkg::*; (
    input  logic     clk_pix,      // pixel clock
    input  logic     rst_pix,      // sync reset, active high
    disp_if.snk      t_if,         // slot from the timing stage
    input  pat_cmd_t active_cmd,   // pattern in force
    disp_if.src      r_if          // slot with colour filled in
);

    int         bar_n;       // raw bar number
    logic [2:0] bar_idx;     // bar number clamped to 0..7
    logic [3:0] cell_k;      // grid bit select, at most 8
    logic       grid_on;     // pixel inside a set cell
    rgb565_t    fg565;       // grid foreground widened
    rgb565_t    colour;      // colour for this slot

    // bars, 60 pixels each
    assign bar_n   = int'(t_if.sx) / BAR_W;
    assign bar_idx = (bar_n < 0) ? 3'd0 :          // blanking, masked later
                     (bar_n > 7) ? 3'd7 : bar_n[2:0];

    // checker, cells of 2^k pixels
    assign cell_k  = (active_cmd.arg.grid.cell_log2 > 4'd8) ? 4'd8
                                                           : active_cmd.arg.grid.cell_log2;
    assign grid_on = t_if.sx[cell_k] ^ t_if.sy[cell_k];

    // rgb444 to rgb565 by repeating the top bits
    assign fg565.r = {active_cmd.arg.grid.fg.r, active_cmd.arg.grid.fg.r[3]};
    assign fg565.g = {active_cmd.arg.grid.fg.g, active_cmd.arg.grid.fg.g[3:2]};
    assign fg565.b = {active_cmd.arg.grid.fg.b, active_cmd.arg.grid.fg.b[3]};

    always_comb begin
        case (active_cmd.mode)
            PAT_BARS: begin
                colour.r = bar_idx[2] ? 5'd31 : 5'd0;
                colour.g = bar_idx[1] ? 6'd63 : 6'd0;
                colour.b = bar_idx[0] ? 5'd31 : 5'd0;
            end
            PAT_SOLID: colour = active_cmd.arg.solid;   // argument read as colour
            PAT_GRID:  colour = grid_on ? fg565 : '0;   // argument read as grid
            default:   colour = '0;                     // reserved, black
        endcase
    end

    // control fields, one clock delay
    always_ff @(posedge clk_pix) begin
        r_if.hsync <= t_if.hsync;
        r_if.vsync <= t_if.vsync;
        r_if.de    <= t_if.de;
        r_if.frame <= t_if.frame;
        r_if.line  <= t_if.line;
        if (rst_pix) begin
            r_if.hsync <= 1'b1;
            r_if.vsync <= 1'b1;
            r_if.de    <= 1'b0;
            r_if.frame <= 1'b0;
            r_if.line  <= 1'b0;
        end
    end

    // payload, same delay
    always_ff @(posedge clk_pix) begin
        r_if.sx  <= t_if.sx;
        r_if.sy  <= t_if.sy;
        r_if.rgb <= colour;
    end

endmodule

//--- design/video_out.sv
// ################################################
// video output stage
// blanking and registered panel pins
// ################################################

`timescale 1ns/1ps

module video_out import display_timing_pkg::*, pattern_pkg::*; (
    input  logic    clk_pix,   // pixel clock
    input  logic    rst_pix,   // sync reset, active high
    disp_if.snk     r_if,      // slot from the render stage
    output logic    hsync,     // panel hsync, active low
    output logic    vsync,     // panel vsync, active low
    output logic    de,        // panel data enable
    output logic    frame,     // frame start marker
    output coord_t  sx,        // position, aligned with the pins
    output coord_t  sy,
    output rgb565_t rgb        // panel colour, zero in blanking
);

    always_ff @(posedge clk_pix) begin
        hsync <= r_if.hsync;
        vsync <= r_if.vsync;
        de    <= r_if.de;
        frame <= r_if.frame;
        rgb   <= r_if.de ? r_if.rgb : '0;   // black outside active area
        if (rst_pix) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            rgb   <= '0;
        end
    end

    always_ff @(posedge clk_pix) begin
        sx <= r_if.sx;
        sy <= r_if.sy;
    end

    // panel never sees colour in blanking
    a_blank: assert property (
        @(posedge clk_pix) disable iff (rst_pix)
        !de |-> (rgb == '0)
    ) else $error("rgb not zero with de low");

endmodule

//--- display_top.f
+incdir+tb
design/display_timing_pkg.sv
design/pattern_pkg.sv
design/disp_if.sv
design/display_272p.sv
design/pattern_cmd_latch.sv
design/pattern_render.sv
design/video_out.sv
design/display_top.sv
tb/tb_display_top.sv

//--- tb/tb_display_model.svh
// ################################################
// display reference model
// expected raster position and pixel colour per rules
// ################################################

`ifndef TB_DISPLAY_MODEL_SVH
`define TB_DISPLAY_MODEL_SVH

// column of the n-th clock after a frame pulse
function automatic coord_t raster_x(int n);
    return coord_t'(H_STA + n % H_TOTAL);
endfunction

// row of the n-th clock after a frame pulse
function automatic coord_t raster_y(int n);
    return coord_t'(V_STA + n / H_TOTAL);
endfunction

function automatic logic in_active(coord_t x, coord_t y);
    return (x >= 0 && x < H_RES && y >= 0 && y < V_RES);
endfunction

// colour the pins should carry at an active position
function automatic rgb565_t exp_colour(coord_t x, coord_t y, pat_cmd_t cmd);
    rgb565_t     c;
    int          idx;
    int          k;
    logic [15:0] ux;
    logic [15:0] uy;
    c   = '0;
    ux  = x;
    uy  = y;
    idx = (int'(x) / BAR_W > 7) ? 7 : int'(x) / BAR_W;                  // bar number
    k   = (cmd.arg.grid.cell_log2 > 8) ? 8 : int'(cmd.arg.grid.cell_log2);   // cell bit
    case (cmd.mode)
        PAT_BARS: begin
            c.r = idx[2] ? 5'd31 : 5'd0;
            c.g = idx[1] ? 6'd63 : 6'd0;
            c.b = idx[0] ? 5'd31 : 5'd0;
        end
        PAT_SOLID: c = cmd.arg.solid;
        PAT_GRID: begin
            if (ux[k] != uy[k]) begin                  // odd cell, foreground
                c.r = {cmd.arg.grid.fg.r, cmd.arg.grid.fg.r[3]};
                c.g = {cmd.arg.grid.fg.g, cmd.arg.grid.fg.g[3:2]};
                c.b = {cmd.arg.grid.fg.b, cmd.arg.grid.fg.b[3]};
            end
        end
        default: c = '0;                               // reserved mode
    endcase
    return c;
endfunction

`endif

//--- tb/tb_display_top.sv
// ################################################
// display top testbench
// raster, pattern commands, blanking and handshake
// ################################################

`timescale 1ns/1ps

module tb_display_top import display_timing_pkg::*, pattern_pkg::*; ();

    localparam int TIMEOUT = 200000;   // clocks per wait

    logic      clk_pix;
    logic      rst_pix;
    logic      cmd_req;
    pat_mode_t cmd_mode;
    pat_arg_u  cmd_arg;
    logic      cmd_ack;
    logic      hsync;
    logic      vsync;
    logic      de;
    logic      frame;
    coord_t    sx;
    coord_t    sy;
    rgb565_t   rgb;

    integer   seed = 6;
    int       checks = 0;
    int       errors = 0;
    int       tests = 0;
    int       fails = 0;
    int       pix_n = 0;            // clocks since pin frame pulse
    logic     synced = 1'b0;        // raster model locked to frame
    logic     next_valid = 1'b0;
    logic     ack_prev = 1'b0;
    pat_cmd_t sent_cmd = CMD_RESET; // last command driven by host
    pat_cmd_t next_cmd = CMD_RESET;
    pat_cmd_t cur_cmd = CMD_RESET;  // command the pins should show

    `include "tb_display_model.svh"

    display_top u_dut (.*);

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;   // 25 MHz
    end

    task automatic check_rgb(rgb565_t got, rgb565_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: rgb %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_coord(coord_t got, coord_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_ack(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: cmd_ack %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[FAIL] %0t %s: %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(string why);
        $display("timed out waiting for %s", why);
        $display("sim failed");
        $finish;
    endtask

    // next frame pulse at the pins
    task automatic wait_frame(string why);
        int n;
        n = 0;
        @(negedge clk_pix);
        while (frame !== 1'b1) begin
            if (n == TIMEOUT) abort_run(why);
            @(negedge clk_pix);
            n++;
        end
    endtask

    task automatic wait_ack(logic level, string why);
        int n;
        n = 0;
        while (cmd_ack !== level) begin
            if (n == TIMEOUT) abort_run(why);
            @(negedge clk_pix);
            n++;
        end
    endtask

    task automatic check_idle_pins(string what);
        check_level(hsync, 1'b1, {what, " hsync"});
        check_level(vsync, 1'b1, {what, " vsync"});
        check_level(de, 1'b0, {what, " de"});
        check_level(frame, 1'b0, {what, " frame"});
        check_ack(cmd_ack, 1'b0, what);
    endtask

    // raise req, ack must lead the pin frame pulse by two clocks
    task automatic send_cmd(pat_mode_t mode, pat_arg_u arg);
        int n;
        @(posedge clk_pix);
        sent_cmd  = '{mode: mode, arg: arg};
        cmd_mode <= mode;
        cmd_arg  <= arg;
        cmd_req  <= 1'b1;
        wait_ack(1'b1, "cmd_ack high");
        n = 0;
        while (frame !== 1'b1 && n < 8) begin
            @(negedge clk_pix);
            n++;
        end
        check_count(n, 2, "clocks from ack to frame");
    endtask

    // drop req, ack falls on the clock after
    task automatic release_cmd();
        @(posedge clk_pix);
        cmd_req <= 1'b0;
        @(negedge clk_pix);
        check_ack(cmd_ack, 1'b1, "ack before req low seen");
        @(negedge clk_pix);
        check_ack(cmd_ack, 1'b0, "ack after req low");
        wait_ack(1'b0, "cmd_ack low");
    endtask

    task automatic hold_frames(int count);
        int n;
        repeat (count) begin
            n = 0;
            @(negedge clk_pix);
            while (frame !== 1'b1) begin
                check_ack(cmd_ack, 1'b1, "held request");
                if (n == TIMEOUT) abort_run("held frame");
                @(negedge clk_pix);
                n++;
            end
        end
    endtask

    // line and frame counts over one frame
    task automatic measure_frame();
        int n;
        int de_run;
        int hs_run;
        int vs_low;
        int lines;
        n      = 0;
        de_run = 0;
        hs_run = 0;
        vs_low = 0;
        lines  = 0;
        wait_frame("raster frame start");
        while (frame !== 1'b1 || n == 0) begin
            @(negedge clk_pix);
            n++;
            if (n == TIMEOUT) abort_run("raster frame end");
            if (de) de_run++;
            else if (de_run > 0) begin
                check_count(de_run, H_RES, "de clocks per line");
                lines++;
                de_run = 0;
            end
            if (!hsync) hs_run++;
            else if (hs_run > 0) begin
                check_count(hs_run, H_SYNC, "hsync low clocks");
                hs_run = 0;
            end
            if (!vsync) vs_low++;   // whole sync lines
        end
        check_count(n, H_TOTAL * V_TOTAL, "clocks per frame");
        check_count(vs_low, V_SYNC * H_TOTAL, "vsync low clocks");
        check_count(lines, V_RES, "active lines");
    endtask

    task automatic report_test(string name, int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            fails++;
            $display("test %0d %s: %0d errors", tests, name, errors - err_before);
        end
    endtask

    // compare process, every clock against the model
    always @(negedge clk_pix) begin : compare
        coord_t ex;
        coord_t ey;
        if (rst_pix) begin
            synced     = 1'b0;
            next_valid = 1'b0;
            ack_prev   = 1'b0;
            cur_cmd    = CMD_RESET;
        end else begin
            if (frame) begin
                pix_n  = 0;
                synced = 1'b1;
                if (next_valid) cur_cmd = next_cmd;   // new pattern from this frame
                next_valid = 1'b0;
            end
            if (synced) begin
                ex = raster_x(pix_n);
                ey = raster_y(pix_n);
                check_level(de, in_active(ex, ey), "de");
                if (de) begin
                    check_coord(sx, ex, "sx");
                    check_coord(sy, ey, "sy");
                    check_rgb(rgb, exp_colour(ex, ey, cur_cmd), "active pixel");
                end else begin
                    check_rgb(rgb, '0, "blanking");
                end
                pix_n++;
            end
            if (cmd_ack && !ack_prev) begin          // command taken, shows next frame
                next_cmd   = sent_cmd;
                next_valid = 1'b1;
            end
            ack_prev = cmd_ack;
        end
    end

    initial begin
        int          e;
        logic [31:0] rnd;
        pat_arg_u    arg;
        rst_pix  = 1'b1;
        cmd_req  = 1'b0;
        cmd_mode = PAT_BARS;
        cmd_arg  = '0;

        e = errors;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk_pix);
            if (i == 3) rst_pix <= 1'b0;   // fourth edge still in reset
            @(negedge clk_pix);
            check_idle_pins("in reset");
        end
        @(negedge clk_pix);
        check_idle_pins("after reset");
        report_test("reset", e);

        e = errors;
        measure_frame();
        report_test("bars and raster", e);

        e = errors;
        rnd = $random(seed);
        arg = rnd[15:0];
        send_cmd(PAT_SOLID, arg);
        release_cmd();
        wait_frame("solid frame end");
        report_test("solid", e);

        e = errors;
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);
            arg = rnd[15:0];
            if (i == 1) arg.grid.cell_log2 = 4'd9 + rnd[17:16];   // beyond the clamp
            send_cmd(PAT_GRID, arg);
            release_cmd();
            wait_frame("grid frame end");
        end
        report_test("grid", e);

        e = errors;
        rnd = $random(seed);
        arg = rnd[15:0];
        send_cmd(PAT_RSVD, arg);
        release_cmd();
        wait_frame("reserved frame end");
        report_test("blanking", e);

        e = errors;
        rnd = $random(seed);
        arg = rnd[15:0];
        send_cmd(PAT_SOLID, arg);
        hold_frames(2);
        release_cmd();
        wait_frame("held frame end");
        report_test("held request", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, fails, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
